// File: csr_pkg.sv
// CSR file shared definitions
// Addresses, writable-bit masks, reset values and enums for the
// machine-mode CSR file of a small RV32 core with M and U modes

`default_nettype none

package csr_pkg;

  typedef logic [31:0] csr_word_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_level_t;

  typedef enum logic [2:0] {
    CSR_NONE,
    CSR_READ,
    CSR_WRITE,
    CSR_SET,
    CSR_CLEAR
  } csr_op_t;

  typedef enum logic [1:0] {
    TVEC_DIRECT   = 2'd0,
    TVEC_VECTORED = 2'd1
  } tvec_mode_t;

  // Machine trap setup and handling
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  // Machine counters
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;
  // Machine information, read only
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;
  localparam csr_addr_t MCONFIGPTR_ADDR    = 12'hF15;
  // User counter views
  localparam csr_addr_t CYCLE_ADDR         = 12'hC00;
  localparam csr_addr_t TIME_ADDR          = 12'hC01;
  localparam csr_addr_t INSTRET_ADDR       = 12'hC02;
  localparam csr_addr_t CYCLEH_ADDR        = 12'hC80;
  localparam csr_addr_t TIMEH_ADDR         = 12'hC81;
  localparam csr_addr_t INSTRETH_ADDR      = 12'hC82;

  localparam csr_word_t HART_ID    = 32'h0;
  localparam csr_word_t MISA_VALUE = 32'h4010_1100;  // RV32 with I, M, U

  localparam csr_word_t MSTATUS_MASK       = 32'h0022_1888;  // mie mpie mpp mprv tw
  localparam csr_word_t MIE_MASK           = 32'h0000_0888;
  localparam csr_word_t MCOUNTEREN_MASK    = 32'h0000_0007;
  localparam csr_word_t MCOUNTINHIBIT_MASK = 32'h0000_0005;

  localparam csr_word_t MSTATUS_RESET    = 32'h0020_0000;  // tw set, mpp user
  localparam csr_word_t MCOUNTEREN_RESET = 32'h0000_0007;

  localparam int MIE_BIT  = 3;
  localparam int MPIE_BIT = 7;
  localparam int MPP_LSB  = 11;

  localparam int CY_BIT = 0;
  localparam int TM_BIT = 1;
  localparam int IR_BIT = 2;

endpackage

`default_nettype wire

// File: csr_access_check.sv
// CSR access check
// Applies privilege and read-only rules, merges set and clear with the
// old value and gates the register write

`default_nettype none

module csr_access_check import csr_pkg::*; (
  input  csr_op_t     csr_op,
  input  csr_addr_t   csr_addr,
  input  csr_word_t   csr_wdata,
  input  priv_level_t priv,
  input  csr_word_t   old_val,
  input  logic        addr_fault,
  output csr_word_t   new_val,
  output logic        wr_en,
  output logic        csr_invalid
);

  logic active;
  logic modify;
  logic ro_fault;
  logic priv_fault;

  assign active     = (csr_op != CSR_NONE);
  assign modify     = csr_op inside {CSR_WRITE, CSR_SET, CSR_CLEAR};
  assign ro_fault   = (csr_addr[11:10] == 2'b11) && modify;  // Read-only space
  assign priv_fault = csr_addr[9:8] > priv;

  assign csr_invalid = active && (ro_fault || priv_fault || addr_fault);
  assign wr_en       = modify && !csr_invalid;

  always_comb begin
    case (csr_op)
      CSR_SET:   new_val = old_val | csr_wdata;
      CSR_CLEAR: new_val = old_val & ~csr_wdata;
      default:   new_val = csr_wdata;
    endcase
  end

endmodule

`default_nettype wire

// File: csr_machine_regs.sv
// Machine trap-setup and trap-handling registers
// Legalizes software writes and applies the trap update, which wins
// over a write in the same cycle

`default_nettype none

module csr_machine_regs import csr_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        wr_en,
  input  csr_addr_t   csr_addr,
  input  csr_word_t   new_val,
  input  logic        trap_valid,
  input  csr_word_t   trap_cause,
  input  csr_word_t   trap_epc,
  input  csr_word_t   trap_tval,
  input  priv_level_t priv,
  output csr_word_t   mstatus,
  output csr_word_t   mtvec,
  output csr_word_t   mie,
  output csr_word_t   mscratch,
  output csr_word_t   mepc,
  output csr_word_t   mcause,
  output csr_word_t   mtval,
  output csr_word_t   mcounteren,
  output csr_word_t   mcountinhibit,
  output logic        cur_mie_global
);

  csr_word_t mstatus_next, mtvec_next, mie_next, mscratch_next;
  csr_word_t mepc_next, mcause_next, mtval_next;
  csr_word_t mcounteren_next, mcountinhibit_next;
  csr_word_t mstatus_legal, mtvec_legal;

  // Unsupported mpp encodings fall back to user mode
  always_comb begin
    mstatus_legal = new_val & MSTATUS_MASK;
    if (mstatus_legal[MPP_LSB +: 2] inside {2'b01, 2'b10}) begin
      mstatus_legal[MPP_LSB +: 2] = PRIV_U;
    end
    mtvec_legal = new_val;
    if (new_val[1:0] > 2'd1) begin
      mtvec_legal[1:0] = TVEC_DIRECT;  // Reserved mode
    end
  end

  always_comb begin
    mstatus_next       = mstatus;
    mtvec_next         = mtvec;
    mie_next           = mie;
    mscratch_next      = mscratch;
    mepc_next          = mepc;
    mcause_next        = mcause;
    mtval_next         = mtval;
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;

    if (wr_en) begin
      case (csr_addr)
        MSTATUS_ADDR:       mstatus_next = mstatus_legal;
        MTVEC_ADDR:         mtvec_next = mtvec_legal;
        MIE_ADDR:           mie_next = new_val & MIE_MASK;
        MSCRATCH_ADDR:      mscratch_next = new_val;
        MEPC_ADDR:          mepc_next = new_val;
        MCAUSE_ADDR:        mcause_next = new_val;
        MTVAL_ADDR:         mtval_next = new_val;
        MCOUNTEREN_ADDR:    mcounteren_next = new_val & MCOUNTEREN_MASK;
        MCOUNTINHIBIT_ADDR: mcountinhibit_next = new_val & MCOUNTINHIBIT_MASK;
        default: ;
      endcase
    end

    // Trap entry built from the current state
    if (trap_valid) begin
      mepc_next   = trap_epc;
      mcause_next = trap_cause;
      mtval_next  = trap_tval;
      mstatus_next = mstatus;
      mstatus_next[MPIE_BIT]       = mstatus[MIE_BIT];
      mstatus_next[MIE_BIT]        = 1'b0;
      mstatus_next[MPP_LSB +: 2]   = priv;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= MSTATUS_RESET;
      mtvec         <= '0;
      mie           <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= MCOUNTEREN_RESET;
      mcountinhibit <= '0;
    end else begin
      mstatus       <= mstatus_next;
      mtvec         <= mtvec_next;
      mie           <= mie_next;
      mscratch      <= mscratch_next;
      mepc          <= mepc_next;
      mcause        <= mcause_next;
      mtval         <= mtval_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
    end
  end

  assign cur_mie_global = mstatus[MIE_BIT];

  // Neither writes nor trap entry may leave a supervisor or reserved mpp
  a_mpp_legal : assert property (@(posedge CLK) disable iff (!nRST)
    !(mstatus[MPP_LSB +: 2] inside {2'b01, 2'b10}));

endmodule

`default_nettype wire

// File: csr_counters.sv
// Cycle and retired-instruction counters, 64 bits each
// Each steps unless inhibited; a software write to a half replaces it

`default_nettype none

module csr_counters import csr_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        wr_en,
  input  csr_addr_t   csr_addr,
  input  csr_word_t   new_val,
  input  logic        inst_ret,
  input  csr_word_t   mcountinhibit,
  output logic [63:0] mcycle_full,
  output logic [63:0] minstret_full
);

  // Software write to either half takes precedence over the step
  function automatic logic [63:0] step_count(
    input logic [63:0] cur,
    input logic        inc,
    input logic        wr_lo,
    input logic        wr_hi,
    input csr_word_t   val
  );
    logic [63:0] nxt;
    nxt = cur + 64'(inc);
    if (wr_lo) nxt = {cur[63:32], val};
    if (wr_hi) nxt = {val, cur[31:0]};
    return nxt;
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mcycle_full   <= '0;
      minstret_full <= '0;
    end else begin
      mcycle_full <= step_count(mcycle_full, !mcountinhibit[CY_BIT],
        wr_en && (csr_addr == MCYCLE_ADDR), wr_en && (csr_addr == MCYCLEH_ADDR), new_val);
      minstret_full <= step_count(minstret_full, inst_ret && !mcountinhibit[IR_BIT],
        wr_en && (csr_addr == MINSTRET_ADDR), wr_en && (csr_addr == MINSTRETH_ADDR), new_val);
    end
  end

endmodule

`default_nettype wire

// File: csr_read_mux.sv
// CSR read select
// Decodes the address to the old value and flags unmapped addresses
// and user counter reads that mcounteren does not allow

`default_nettype none

module csr_read_mux import csr_pkg::*; (
  input  csr_addr_t   csr_addr,
  input  priv_level_t priv,
  input  logic [63:0] mtime,
  input  logic [63:0] mcycle_full,
  input  logic [63:0] minstret_full,
  input  csr_word_t   mstatus,
  input  csr_word_t   mtvec,
  input  csr_word_t   mie,
  input  csr_word_t   mscratch,
  input  csr_word_t   mepc,
  input  csr_word_t   mcause,
  input  csr_word_t   mtval,
  input  csr_word_t   mcounteren,
  input  csr_word_t   mcountinhibit,
  output csr_word_t   old_val,
  output logic        addr_fault
);

  logic user_mode;
  assign user_mode = (priv == PRIV_U);

  always_comb begin
    old_val    = '0;
    addr_fault = 1'b0;
    case (csr_addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MCONFIGPTR_ADDR: old_val = '0;
      MHARTID_ADDR:       old_val = HART_ID;
      MISA_ADDR:          old_val = MISA_VALUE;
      MSTATUS_ADDR:       old_val = mstatus;
      MTVEC_ADDR:         old_val = mtvec;
      MIE_ADDR:           old_val = mie;
      MSCRATCH_ADDR:      old_val = mscratch;
      MEPC_ADDR:          old_val = mepc;
      MCAUSE_ADDR:        old_val = mcause;
      MTVAL_ADDR:         old_val = mtval;
      MCOUNTEREN_ADDR:    old_val = mcounteren;
      MCOUNTINHIBIT_ADDR: old_val = mcountinhibit;
      MCYCLE_ADDR:        old_val = mcycle_full[31:0];
      MCYCLEH_ADDR:       old_val = mcycle_full[63:32];
      MINSTRET_ADDR:      old_val = minstret_full[31:0];
      MINSTRETH_ADDR:     old_val = minstret_full[63:32];
      // User views, gated per counter
      CYCLE_ADDR, CYCLEH_ADDR: begin
        addr_fault = user_mode && !mcounteren[CY_BIT];
        old_val    = csr_addr[7] ? mcycle_full[63:32] : mcycle_full[31:0];
      end
      TIME_ADDR, TIMEH_ADDR: begin
        addr_fault = user_mode && !mcounteren[TM_BIT];
        old_val    = csr_addr[7] ? mtime[63:32] : mtime[31:0];
      end
      INSTRET_ADDR, INSTRETH_ADDR: begin
        addr_fault = user_mode && !mcounteren[IR_BIT];
        old_val    = csr_addr[7] ? minstret_full[63:32] : minstret_full[31:0];
      end
      default: addr_fault = 1'b1;  // Unmapped
    endcase
  end

endmodule

`default_nettype wire

// File: csr_file.sv
// Machine-mode CSR file, top level
// Connects the access check, register, counter and read-select blocks

`default_nettype none

module csr_file import csr_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  csr_op_t     csr_op,
  input  csr_addr_t   csr_addr,
  input  csr_word_t   csr_wdata,
  input  priv_level_t priv,
  input  logic        inst_ret,
  input  logic [63:0] mtime,
  input  logic        trap_valid,
  input  csr_word_t   trap_cause,
  input  csr_word_t   trap_epc,
  input  csr_word_t   trap_tval,
  output csr_word_t   csr_rdata,
  output logic        csr_invalid,
  output csr_word_t   cur_mtvec,
  output csr_word_t   cur_mepc,
  output logic        cur_mie_global
);

  csr_word_t   old_val, new_val;
  logic        addr_fault, wr_en;
  csr_word_t   mstatus, mtvec, mie, mscratch, mepc, mcause, mtval;
  csr_word_t   mcounteren, mcountinhibit;
  logic [63:0] mcycle_full, minstret_full;

  csr_access_check i_access_check (.csr_op, .csr_addr, .csr_wdata, .priv, .old_val,
    .addr_fault, .new_val, .wr_en, .csr_invalid);

  csr_machine_regs i_machine_regs (.CLK, .nRST, .wr_en, .csr_addr, .new_val, .trap_valid,
    .trap_cause, .trap_epc, .trap_tval, .priv, .mstatus, .mtvec, .mie, .mscratch, .mepc,
    .mcause, .mtval, .mcounteren, .mcountinhibit, .cur_mie_global);

  csr_counters i_counters (.CLK, .nRST, .wr_en, .csr_addr, .new_val, .inst_ret,
    .mcountinhibit, .mcycle_full, .minstret_full);

  csr_read_mux i_read_mux (.csr_addr, .priv, .mtime, .mcycle_full, .minstret_full, .mstatus,
    .mtvec, .mie, .mscratch, .mepc, .mcause, .mtval, .mcounteren, .mcountinhibit, .old_val,
    .addr_fault);

  assign csr_rdata = old_val;  // Value before this access
  assign cur_mtvec = mtvec;
  assign cur_mepc  = mepc;

endmodule

`default_nettype wire

// File: tb_csr_file.sv
// Testbench for the machine-mode CSR file
// Drives CSR accesses, counter activity and trap strobes, and checks each
// response against a shadow-register reference model

`default_nettype none

module tb_csr_file import csr_pkg::*; ();

  localparam int MAX_CYCLES = 400;  // About 130 test cycles, with a wide margin

  logic        CLK = 1'b0;
  logic        nRST;
  csr_op_t     csr_op;
  csr_addr_t   csr_addr;
  csr_word_t   csr_wdata;
  priv_level_t priv;
  logic        inst_ret;
  logic [63:0] mtime;
  logic        trap_valid;
  csr_word_t   trap_cause, trap_epc, trap_tval;
  csr_word_t   csr_rdata, cur_mtvec, cur_mepc;
  logic        csr_invalid, cur_mie_global;

  // Shadow registers of the reference model
  csr_word_t   s_mstatus, s_mtvec, s_mie, s_mscratch, s_mepc, s_mcause, s_mtval;
  csr_word_t   s_mcounteren, s_mcountinhibit;
  logic [63:0] s_mcycle, s_minstret;

  // Expected outputs for the cycle being driven
  csr_word_t   exp_rdata, exp_mtvec, exp_mepc;
  logic        exp_invalid, exp_mie_global;
  logic        chk_armed, chk_access;
  int          err_count = 0;
  int          cycle_count = 0;

  csr_file i_csr_file (.CLK, .nRST, .csr_op, .csr_addr, .csr_wdata, .priv, .inst_ret, .mtime,
    .trap_valid, .trap_cause, .trap_epc, .trap_tval, .csr_rdata, .csr_invalid, .cur_mtvec,
    .cur_mepc, .cur_mie_global);

  always #10 CLK = ~CLK;

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
    if (got !== exp) begin
      err_count++;
      fail_stop($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      fail_stop($sformatf("Fail at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // Expected old value and invalid flag for one access
  function automatic logic ref_access(input csr_op_t op, input csr_addr_t addr,
                                      input priv_level_t p, output csr_word_t val);
    logic fault;
    logic user;
    logic modify;
    fault  = 1'b0;
    user   = (p == PRIV_U);
    modify = (op == CSR_WRITE) || (op == CSR_SET) || (op == CSR_CLEAR);
    val    = '0;
    case (addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MCONFIGPTR_ADDR: val = '0;
      MHARTID_ADDR:       val = HART_ID;
      MISA_ADDR:          val = MISA_VALUE;
      MSTATUS_ADDR:       val = s_mstatus;
      MTVEC_ADDR:         val = s_mtvec;
      MIE_ADDR:           val = s_mie;
      MSCRATCH_ADDR:      val = s_mscratch;
      MEPC_ADDR:          val = s_mepc;
      MCAUSE_ADDR:        val = s_mcause;
      MTVAL_ADDR:         val = s_mtval;
      MCOUNTEREN_ADDR:    val = s_mcounteren;
      MCOUNTINHIBIT_ADDR: val = s_mcountinhibit;
      MCYCLE_ADDR:        val = s_mcycle[31:0];
      MCYCLEH_ADDR:       val = s_mcycle[63:32];
      MINSTRET_ADDR:      val = s_minstret[31:0];
      MINSTRETH_ADDR:     val = s_minstret[63:32];
      CYCLE_ADDR, CYCLEH_ADDR: begin
        val   = (addr == CYCLEH_ADDR) ? s_mcycle[63:32] : s_mcycle[31:0];
        fault = user && !s_mcounteren[CY_BIT];
      end
      TIME_ADDR, TIMEH_ADDR: begin
        val   = (addr == TIMEH_ADDR) ? mtime[63:32] : mtime[31:0];
        fault = user && !s_mcounteren[TM_BIT];
      end
      INSTRET_ADDR, INSTRETH_ADDR: begin
        val   = (addr == INSTRETH_ADDR) ? s_minstret[63:32] : s_minstret[31:0];
        fault = user && !s_mcounteren[IR_BIT];
      end
      default: fault = 1'b1;  // Not implemented
    endcase
    return (op != CSR_NONE) && (((addr[11:10] == 2'b11) && modify) || (addr[9:8] > p) || fault);
  endfunction

  // State after the coming clock edge
  task automatic model_commit(input csr_op_t op, input csr_addr_t addr, input csr_word_t wdata,
                              input priv_level_t p, input logic ret, input logic trap,
                              input csr_word_t old, input logic inv);
    csr_word_t   nv;
    csr_word_t   st;
    logic        wen;
    logic [63:0] cyc;
    logic [63:0] ins;
    case (op)
      CSR_SET:   nv = old | wdata;
      CSR_CLEAR: nv = old & ~wdata;
      default:   nv = wdata;
    endcase
    wen = ((op == CSR_WRITE) || (op == CSR_SET) || (op == CSR_CLEAR)) && !inv;
    st  = s_mstatus;
    cyc = s_mcycle + 64'(!s_mcountinhibit[CY_BIT]);
    ins = s_minstret + 64'(ret && !s_mcountinhibit[IR_BIT]);
    if (wen) begin
      case (addr)
        MSTATUS_ADDR: begin
          s_mstatus = nv & MSTATUS_MASK;
          if (s_mstatus[MPP_LSB +: 2] == 2'b01 || s_mstatus[MPP_LSB +: 2] == 2'b10)
            s_mstatus[MPP_LSB +: 2] = 2'b00;  // Only M and U exist
        end
        MTVEC_ADDR: begin
          s_mtvec = nv;
          if (nv[1:0] > 2'd1) s_mtvec[1:0] = 2'd0;
        end
        MIE_ADDR:           s_mie = nv & MIE_MASK;
        MSCRATCH_ADDR:      s_mscratch = nv;
        MEPC_ADDR:          s_mepc = nv;
        MCAUSE_ADDR:        s_mcause = nv;
        MTVAL_ADDR:         s_mtval = nv;
        MCOUNTEREN_ADDR:    s_mcounteren = nv & MCOUNTEREN_MASK;
        MCOUNTINHIBIT_ADDR: s_mcountinhibit = nv & MCOUNTINHIBIT_MASK;
        MCYCLE_ADDR:        cyc = {s_mcycle[63:32], nv};  // No step this cycle
        MCYCLEH_ADDR:       cyc = {nv, s_mcycle[31:0]};
        MINSTRET_ADDR:      ins = {s_minstret[63:32], nv};
        MINSTRETH_ADDR:     ins = {nv, s_minstret[31:0]};
        default: ;
      endcase
    end
    s_mcycle   = cyc;
    s_minstret = ins;
    // Trap entry overrides any write to the same registers
    if (trap) begin
      s_mepc                  = trap_epc;
      s_mcause                = trap_cause;
      s_mtval                 = trap_tval;
      s_mstatus               = st;
      s_mstatus[MPIE_BIT]     = st[MIE_BIT];
      s_mstatus[MIE_BIT]      = 1'b0;
      s_mstatus[MPP_LSB +: 2] = p;
    end
  endtask

  // One clock cycle, starting and ending on a falling edge
  task automatic step(input csr_op_t op, input csr_addr_t addr, input csr_word_t wdata,
                      input priv_level_t p, input logic ret, input logic trap);
    csr_word_t val;
    logic      inv;
    csr_op     = op;
    csr_addr   = addr;
    csr_wdata  = wdata;
    priv       = p;
    inst_ret   = ret;
    trap_valid = trap;
    inv = ref_access(op, addr, p, val);
    exp_rdata      = val;
    exp_invalid    = inv;
    exp_mtvec      = s_mtvec;
    exp_mepc       = s_mepc;
    exp_mie_global = s_mstatus[MIE_BIT];
    chk_access     = (op != CSR_NONE);
    chk_armed      = 1'b1;
    model_commit(op, addr, wdata, p, ret, trap, val, inv);
    @(negedge CLK);
  endtask

  task automatic read_csr(input csr_addr_t addr, input priv_level_t p);
    step(CSR_READ, addr, '0, p, 1'b0, 1'b0);
  endtask

  task automatic write_csr(input csr_addr_t addr, input csr_word_t data);
    step(CSR_WRITE, addr, data, PRIV_M, 1'b0, 1'b0);
  endtask

  function automatic csr_op_t pick_op();
    case ($urandom_range(2, 0))
      0:       return CSR_WRITE;
      1:       return CSR_SET;
      default: return CSR_CLEAR;
    endcase
  endfunction

  function automatic csr_addr_t pick_rw_addr();
    case ($urandom_range(6, 0))
      0:       return MSCRATCH_ADDR;
      1:       return MEPC_ADDR;
      2:       return MCAUSE_ADDR;
      3:       return MTVAL_ADDR;
      4:       return MSTATUS_ADDR;
      5:       return MTVEC_ADDR;
      default: return MIE_ADDR;
    endcase
  endfunction

  // Outputs settle well before the rising edge
  always @(negedge CLK) begin
    #5;
    if (chk_armed) begin
      check_word("cur_mepc", cur_mepc, exp_mepc);
      check_word("cur_mtvec", cur_mtvec, exp_mtvec);
      check_bit("cur_mie_global", cur_mie_global, exp_mie_global);
      check_bit("csr_invalid", csr_invalid, exp_invalid);
      if (chk_access && !exp_invalid) check_word("csr_rdata", csr_rdata, exp_rdata);
    end
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      fail_stop("Simulation timed out before the tests finished");
    end
  end

  initial begin
    csr_addr_t   a;
    logic [15:0] pattern;
    void'($urandom(32'hc7dc));
    nRST       = 1'b0;
    csr_op     = CSR_NONE;
    csr_addr   = '0;
    csr_wdata  = '0;
    priv       = PRIV_M;
    inst_ret   = 1'b0;
    mtime      = '0;
    trap_valid = 1'b0;
    trap_cause = '0;
    trap_epc   = '0;
    trap_tval  = '0;
    chk_armed  = 1'b0;
    chk_access = 1'b0;
    s_mstatus  = MSTATUS_RESET;
    s_mtvec    = '0;
    s_mie      = '0;
    s_mscratch = '0;
    s_mepc     = '0;
    s_mcause   = '0;
    s_mtval    = '0;
    s_mcounteren    = MCOUNTEREN_RESET;
    s_mcountinhibit = '0;
    s_mcycle   = '0;
    s_minstret = '0;
    pattern    = 16'b1011_0010_1110_0101;
    repeat (2) @(negedge CLK);
    nRST = 1'b1;

    // Reset values
    read_csr(MISA_ADDR, PRIV_M);
    read_csr(MHARTID_ADDR, PRIV_M);
    read_csr(MSTATUS_ADDR, PRIV_M);
    read_csr(MCOUNTEREN_ADDR, PRIV_M);
    read_csr(MTVEC_ADDR, PRIV_M);

    // Random read-modify-write with read back
    for (int i = 0; i < 30; i++) begin
      a = pick_rw_addr();
      step(pick_op(), a, $urandom, PRIV_M, 1'b0, 1'b0);
      read_csr(a, PRIV_M);
    end

    // Illegal accesses leave every register alone
    step(CSR_WRITE, MSCRATCH_ADDR, $urandom, PRIV_U, 1'b0, 1'b0);
    step(CSR_READ, MSTATUS_ADDR, '0, PRIV_U, 1'b0, 1'b0);
    step(CSR_SET, MIE_ADDR, 32'hFFFF_FFFF, PRIV_U, 1'b0, 1'b0);
    write_csr(MVENDORID_ADDR, $urandom);
    write_csr(12'h180, $urandom);  // satp, not implemented
    read_csr(12'h7C0, PRIV_M);
    read_csr(MSCRATCH_ADDR, PRIV_M);
    read_csr(MIE_ADDR, PRIV_M);
    read_csr(MVENDORID_ADDR, PRIV_M);

    // Counters frozen, then minstret counts retire pulses
    write_csr(MCOUNTINHIBIT_ADDR, 32'h5);
    write_csr(MCYCLE_ADDR, $urandom);
    write_csr(MCYCLEH_ADDR, $urandom);
    write_csr(MINSTRET_ADDR, $urandom);
    write_csr(MINSTRETH_ADDR, $urandom);
    read_csr(MCYCLE_ADDR, PRIV_M);
    read_csr(MCYCLEH_ADDR, PRIV_M);
    read_csr(MINSTRET_ADDR, PRIV_M);
    read_csr(MINSTRETH_ADDR, PRIV_M);
    write_csr(MCOUNTINHIBIT_ADDR, 32'h1);
    for (int i = 0; i < 16; i++) begin
      step(CSR_NONE, '0, '0, PRIV_M, pattern[i], 1'b0);
    end
    read_csr(MINSTRET_ADDR, PRIV_M);
    read_csr(MINSTRETH_ADDR, PRIV_M);
    write_csr(MCOUNTINHIBIT_ADDR, 32'h0);
    read_csr(MCYCLE_ADDR, PRIV_M);
    read_csr(MCYCLE_ADDR, PRIV_M);

    // User counter views and mcounteren gating
    mtime = {$urandom, $urandom};
    write_csr(MCOUNTEREN_ADDR, 32'h7);
    read_csr(CYCLE_ADDR, PRIV_U);
    read_csr(INSTRET_ADDR, PRIV_U);
    read_csr(TIME_ADDR, PRIV_U);
    read_csr(TIMEH_ADDR, PRIV_U);
    step(CSR_WRITE, TIME_ADDR, $urandom, PRIV_U, 1'b0, 1'b0);
    write_csr(MCOUNTEREN_ADDR, 32'h2);  // time only
    read_csr(CYCLEH_ADDR, PRIV_U);
    read_csr(TIME_ADDR, PRIV_U);
    read_csr(INSTRETH_ADDR, PRIV_U);
    write_csr(MCOUNTEREN_ADDR, 32'h0);
    read_csr(TIMEH_ADDR, PRIV_U);
    read_csr(TIME_ADDR, PRIV_M);

    // Trap from user mode with interrupts enabled
    step(CSR_SET, MSTATUS_ADDR, 32'h8, PRIV_M, 1'b0, 1'b0);
    trap_cause = 32'h8;
    trap_epc   = $urandom;
    trap_tval  = $urandom;
    step(CSR_NONE, '0, '0, PRIV_U, 1'b0, 1'b1);
    read_csr(MEPC_ADDR, PRIV_M);
    read_csr(MCAUSE_ADDR, PRIV_M);
    read_csr(MTVAL_ADDR, PRIV_M);
    read_csr(MSTATUS_ADDR, PRIV_M);
    // Second trap races a software write to mepc
    trap_cause = 32'h8000_0007;
    trap_epc   = $urandom;
    step(CSR_WRITE, MEPC_ADDR, $urandom, PRIV_M, 1'b0, 1'b1);
    read_csr(MEPC_ADDR, PRIV_M);
    read_csr(MSTATUS_ADDR, PRIV_M);

    if (err_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      fail_stop("Mismatches were recorded during the run");
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
csr_pkg.sv
csr_access_check.sv
csr_machine_regs.sv
csr_counters.sv
csr_read_mux.sv
csr_file.sv
tb_csr_file.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR file testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_csr_file \
  --Mdir obj_dir -o sim_csr_file > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_csr_file > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -eq 0 ] && grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
